/* Makefile */
# Verilator build and run of the cpu queue register testbench

VERILATOR ?= verilator
FILELIST  ?= cpu_queue_regs.f
TB_TOP    ?= cpu_queue_regs_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu_queue_regs.f */
+incdir+source
source/cpu_queue_reg_pkg.sv
source/cpu_queue_stat_pkg.sv
source/delta_accum.sv
source/queue_stats.sv
source/stat_reg_file.sv
source/reg_access.sv
source/cpu_queue_regs.sv
sim/cpu_queue_regs_chk.sv
sim/cpu_queue_regs_tb.sv

/* sim/cpu_queue_regs_chk.sv */
// --------------------
// handshake checks of the register port, bound into reg_access
// assumes req is held until ack and lowered before the next access
// --------------------
`timescale 1ns/1ps

module cpu_queue_regs_chk (
   input logic clk,
   input logic reset,
   input logic req,
   input logic ack
);

   // single cycle pulse
   ack_one_cycle: assert property (
      @(posedge clk) disable iff (reset) ack |=> !ack
   ) else $error("ack stayed high for more than one cycle");

   // one cycle after the request edge
   ack_after_edge: assert property (
      @(posedge clk) disable iff (reset) $rose(req) |=> ack
   ) else $error("ack did not follow the rising edge of req");

   // no ack without a request edge
   ack_has_edge: assert property (
      @(posedge clk) disable iff (reset) ack |-> ($past(req) && !$past(req, 2))
   ) else $error("ack seen without a preceding req edge");

   ack_low_in_reset: assert property (
      @(posedge clk) $past(reset) |-> !ack
   ) else $error("ack high during reset");

endmodule

bind reg_access cpu_queue_regs_chk u_handshake_chk (
   .clk   (clk),
   .reset (reset),
   .req   (req),
   .ack   (ack)
);

/* sim/cpu_queue_regs_tb.sv */
// --------------------
// testbench of the cpu queue register block
// each event kind fires at most once per 12 cycles in a burst
// counters are read only after a burst has settled
// --------------------
`timescale 1ns/1ps
`include "cpu_queue_consts.svh"

module cpu_queue_regs_tb
   import cpu_queue_reg_pkg::*, cpu_queue_stat_pkg::*;
();

   typedef enum logic [2:0] {
      STEP_WR,
      STEP_RD,
      STEP_RDALL,
      STEP_EN,
      STEP_RXB,
      STEP_TXB
   } step_kind_t;

   // one table row, data is the write value or the expected read value
   typedef struct packed {
      step_kind_t  kind;
      reg_addr_t   addr;
      reg_data_t   data;
      logic [15:0] count;
   } step_t;

   localparam int NUM_STEPS = 26;
   localparam int SPACING   = 12;
   localparam int SETTLE    = 30;

   logic      clk = 1'b0;
   logic      reset;
   logic      reg_req;
   logic      reg_rd_wr_l;
   reg_addr_t reg_addr;
   reg_data_t reg_wr_data;
   reg_data_t reg_rd_data;
   logic      reg_ack;
   logic      rx_queue_en;
   logic      tx_queue_en;
   logic      rx_pkt_stored;
   logic      rx_pkt_removed;
   logic      rx_pkt_dropped;
   byte_cnt_t rx_pkt_byte_cnt;
   logic      tx_pkt_stored;
   logic      tx_pkt_removed;
   logic      tx_timeout;
   byte_cnt_t tx_pkt_byte_cnt;

   step_t       steps [NUM_STEPS];
   reg_data_t   model [`CPU_QUEUE_NUM_REGS];
   logic [31:0] lfsr = 32'h7524_8580;
   int          errors;
   int          checks;
   int          cycles = 0;
   int          cycle_limit;

   cpu_queue_regs UUT (.*);

   always #50 clk = ~clk;

   // --------------------
   // timeout
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout, run went past %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic addr_in_map(input reg_addr_t a);
      return (a[`CPU_QUEUE_ADDR_W-1:`CPU_QUEUE_IDX_W] == '0) &&
             (a[`CPU_QUEUE_IDX_W-1:0] < 4'(`CPU_QUEUE_NUM_REGS));
   endfunction

   // --------------------
   // compare tasks
   task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_en(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic idle_events();
      rx_pkt_stored   = 1'b0;
      rx_pkt_removed  = 1'b0;
      rx_pkt_dropped  = 1'b0;
      rx_pkt_byte_cnt = '0;
      tx_pkt_stored   = 1'b0;
      tx_pkt_removed  = 1'b0;
      tx_timeout      = 1'b0;
      tx_pkt_byte_cnt = '0;
   endtask

   // --------------------
   // register port access, req held until ack
   task automatic bus_access(input logic write, input reg_addr_t addr,
                             input reg_data_t data, output reg_data_t rd);
      int waited;
      @(posedge clk);
      #5;
      reg_req     = 1'b1;
      reg_rd_wr_l = !write;
      reg_addr    = addr;
      reg_wr_data = data;
      waited      = 0;
      do begin
         @(posedge clk);
         #5;
         waited++;
      end while (!reg_ack && waited < 8);
      if (!reg_ack) begin
         errors++;
         $display("no ack within %0d cycles for address %h", waited, addr);
      end
      rd          = reg_rd_data;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
   endtask

   task automatic read_all();
      reg_data_t rd;
      for (int r = 0; r < `CPU_QUEUE_NUM_REGS; r++) begin
         bus_access(1'b0, reg_addr_t'(r), '0, rd);
         check_data($sformatf("reg_rd_data[%0d]", r), rd, model[r]);
      end
   endtask

   // random events of one queue, model updated once the burst settled
   task automatic run_burst(input logic tx, input int n);
      logic [31:0] bits;
      logic        st;
      logic        rm;
      logic        ft;
      byte_cnt_t   bc;
      reg_data_t   n_st;
      reg_data_t   n_rm;
      reg_data_t   n_ft;
      reg_data_t   n_bytes;
      int          base;
      base    = tx ? `CPU_QUEUE_TX_BASE : `CPU_QUEUE_RX_BASE;
      n_st    = '0;
      n_rm    = '0;
      n_ft    = '0;
      n_bytes = '0;
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         #5;
         take_bits(15, bits);
         // one chance per kind every SPACING cycles
         st = bits[14] && (i % SPACING == 0);
         rm = bits[13] && (i % SPACING == 4);
         ft = bits[12] && (i % SPACING == 8);
         bc = bits[11:0];
         if (tx) begin
            tx_pkt_stored   = st;
            tx_pkt_removed  = rm;
            tx_timeout      = ft;
            tx_pkt_byte_cnt = bc;
         end else begin
            rx_pkt_stored   = st;
            rx_pkt_removed  = rm;
            rx_pkt_dropped  = ft;
            rx_pkt_byte_cnt = bc;
         end
         n_st = n_st + reg_data_t'(st);
         n_rm = n_rm + reg_data_t'(rm);
         n_ft = n_ft + reg_data_t'(ft);
         // rx counts bytes on dequeue, tx on enqueue
         if (tx ? st : rm) begin
            n_bytes = n_bytes + reg_data_t'(bc);
         end
      end
      @(posedge clk);
      #5;
      idle_events();
      repeat (SETTLE) @(posedge clk);
      model[base + `CPU_QUEUE_OFS_ENQ]   = model[base + `CPU_QUEUE_OFS_ENQ] + n_st;
      model[base + `CPU_QUEUE_OFS_DEQ]   = model[base + `CPU_QUEUE_OFS_DEQ] + n_rm;
      model[base + `CPU_QUEUE_OFS_FAULT] = model[base + `CPU_QUEUE_OFS_FAULT] + n_ft;
      model[base + `CPU_QUEUE_OFS_BYTES] = model[base + `CPU_QUEUE_OFS_BYTES] + n_bytes;
      model[base + `CPU_QUEUE_OFS_INQ]   = model[base + `CPU_QUEUE_OFS_INQ] + n_st - n_rm;
   endtask

   // --------------------
   // stimulus table
   task automatic fill_table();
      steps[0]  = '{STEP_RDALL, 16'h0000, 32'h0000_0000, 16'd0};
      steps[1]  = '{STEP_EN,    16'h0000, 32'h0000_0000, 16'd0};
      steps[2]  = '{STEP_WR,    16'h0000, 32'h0000_0003, 16'd0};
      steps[3]  = '{STEP_RD,    16'h0000, 32'h0000_0003, 16'd0};
      steps[4]  = '{STEP_EN,    16'h0000, 32'h0000_0000, 16'd0};
      steps[5]  = '{STEP_WR,    16'h0000, 32'h1234_5601, 16'd0};
      steps[6]  = '{STEP_RD,    16'h0000, 32'h1234_5601, 16'd0};
      steps[7]  = '{STEP_EN,    16'h0000, 32'h0000_0000, 16'd0};
      steps[8]  = '{STEP_WR,    16'h0000, 32'h0000_0000, 16'd0};
      steps[9]  = '{STEP_EN,    16'h0000, 32'h0000_0000, 16'd0};
      steps[10] = '{STEP_RD,    16'h0100, `CPU_QUEUE_BAD_ADDR_DATA, 16'd0};
      steps[11] = '{STEP_RD,    16'h000b, `CPU_QUEUE_BAD_ADDR_DATA, 16'd0};
      steps[12] = '{STEP_RD,    16'h000f, `CPU_QUEUE_BAD_ADDR_DATA, 16'd0};
      steps[13] = '{STEP_WR,    16'h8003, 32'hffff_ffff, 16'd0};
      steps[14] = '{STEP_WR,    16'h000c, 32'hffff_ffff, 16'd0};
      steps[15] = '{STEP_WR,    16'h0013, 32'hffff_ffff, 16'd0};
      steps[16] = '{STEP_RDALL, 16'h0000, 32'h0000_0000, 16'd0};
      steps[17] = '{STEP_RXB,   16'h0000, 32'h0000_0000, 16'd96};
      steps[18] = '{STEP_RDALL, 16'h0000, 32'h0000_0000, 16'd0};
      steps[19] = '{STEP_TXB,   16'h0000, 32'h0000_0000, 16'd96};
      steps[20] = '{STEP_RDALL, 16'h0000, 32'h0000_0000, 16'd0};
      steps[21] = '{STEP_WR,    16'h0004, 32'h1000_0000, 16'd0};
      steps[22] = '{STEP_WR,    16'h0008, 32'hffff_fff0, 16'd0};
      steps[23] = '{STEP_RXB,   16'h0000, 32'h0000_0000, 16'd60};
      steps[24] = '{STEP_TXB,   16'h0000, 32'h0000_0000, 16'd60};
      steps[25] = '{STEP_RDALL, 16'h0000, 32'h0000_0000, 16'd0};
   endtask

   initial begin
      reg_data_t  rd;
      int         burst_cycles;
      int         err_before;
      step_kind_t kind;
      fill_table();
      burst_cycles = 0;
      for (int s = 0; s < NUM_STEPS; s++) begin
         if (steps[s].kind == STEP_RXB || steps[s].kind == STEP_TXB) begin
            burst_cycles = burst_cycles + int'(steps[s].count) + SETTLE + 1;
         end
      end
      cycle_limit = NUM_STEPS * 40 + burst_cycles;
      errors      = 0;
      checks      = 0;
      reset       = 1'b1;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      idle_events();
      for (int r = 0; r < `CPU_QUEUE_NUM_REGS; r++) begin
         model[r] = '0;
      end
      repeat (5) @(posedge clk);
      #5;
      reset = 1'b0;
      repeat (20) @(posedge clk);

      for (int s = 0; s < NUM_STEPS; s++) begin
         err_before = errors;
         kind       = steps[s].kind;
         case (kind)
            STEP_WR: begin
               bus_access(1'b1, steps[s].addr, steps[s].data, rd);
               if (addr_in_map(steps[s].addr)) begin
                  model[steps[s].addr[`CPU_QUEUE_IDX_W-1:0]] = steps[s].data;
               end
            end
            STEP_RD: begin
               bus_access(1'b0, steps[s].addr, '0, rd);
               check_data("reg_rd_data", rd, steps[s].data);
            end
            STEP_RDALL: read_all();
            STEP_EN: begin
               check_en("rx_queue_en", rx_queue_en,
                        !model[`CPU_QUEUE_CONTROL][`CPU_QUEUE_CTRL_RX_DIS_POS]);
               check_en("tx_queue_en", tx_queue_en,
                        !model[`CPU_QUEUE_CONTROL][`CPU_QUEUE_CTRL_TX_DIS_POS]);
            end
            STEP_RXB: run_burst(1'b0, int'(steps[s].count));
            STEP_TXB: run_burst(1'b1, int'(steps[s].count));
            default: ;
         endcase
         $display("step %0d %s %s", s, kind.name(), (errors == err_before) ? "ok" : "failed");
      end

      $display("steps %0d, checks %0d, errors %0d", NUM_STEPS, checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* source/cpu_queue_consts.svh */
// --------------------
// register map and widths of the cpu queue statistics block
// index 0 is control, then five rx and five tx counters
// counter deltas assume each event kind at most once per sweep
// --------------------
`ifndef CPU_QUEUE_CONSTS_SVH
`define CPU_QUEUE_CONSTS_SVH

// bus and storage widths
`define CPU_QUEUE_DATA_W          32
`define CPU_QUEUE_ADDR_W          16
`define CPU_QUEUE_NUM_REGS        11
`define CPU_QUEUE_IDX_W           4
`define CPU_QUEUE_BYTE_CNT_W      12
`define CPU_QUEUE_DELTA_W         14

// returned for reads outside the register map
`define CPU_QUEUE_BAD_ADDR_DATA   32'hdead_beef

// register indices
`define CPU_QUEUE_CONTROL         0
`define CPU_QUEUE_RX_BASE         1
`define CPU_QUEUE_TX_BASE         6

// offsets inside a queue block, fault is rx drop or tx timeout
`define CPU_QUEUE_OFS_ENQ         0
`define CPU_QUEUE_OFS_DEQ         1
`define CPU_QUEUE_OFS_FAULT       2
`define CPU_QUEUE_OFS_BYTES       3
`define CPU_QUEUE_OFS_INQ         4

// control register bits
`define CPU_QUEUE_CTRL_RX_DIS_POS 0
`define CPU_QUEUE_CTRL_TX_DIS_POS 1

`endif

/* source/cpu_queue_reg_pkg.sv */
// --------------------
// types of the register side, the access port and the sweep
// the access write flag is already qualified by the address check
// --------------------
`include "cpu_queue_consts.svh"

package cpu_queue_reg_pkg;

   // --------------------
   // plain vectors

   typedef logic [`CPU_QUEUE_DATA_W-1:0] reg_data_t;
   typedef logic [`CPU_QUEUE_ADDR_W-1:0] reg_addr_t;
   typedef logic [`CPU_QUEUE_IDX_W-1:0]  reg_idx_t;

   // --------------------
   // one register access, valid for a single cycle

   typedef struct packed {
      logic      valid;
      logic      write;
      reg_idx_t  idx;
      reg_data_t wr_data;
   } reg_access_t;

   // --------------------
   // register file sweep

   typedef enum logic {
      SWEEP_CLEAR,
      SWEEP_RUN
   } sweep_state_t;

endpackage

/* source/cpu_queue_regs.sv */
// --------------------
// statistics and control registers of a cpu dma queue pair
// counts are exact only if each event kind fires once per sweep
// --------------------
`timescale 1ns/1ps
`include "cpu_queue_consts.svh"

module cpu_queue_regs
   import cpu_queue_reg_pkg::*, cpu_queue_stat_pkg::*;
(
   input  logic      clk,
   input  logic      reset,

   // register port
   input  logic      reg_req,
   input  logic      reg_rd_wr_l,
   input  reg_addr_t reg_addr,
   input  reg_data_t reg_wr_data,
   output reg_data_t reg_rd_data,
   output logic      reg_ack,

   // queue enables
   output logic      rx_queue_en,
   output logic      tx_queue_en,

   // rx queue
   input  logic      rx_pkt_stored,
   input  logic      rx_pkt_removed,
   input  logic      rx_pkt_dropped,
   input  byte_cnt_t rx_pkt_byte_cnt,

   // tx queue
   input  logic      tx_pkt_stored,
   input  logic      tx_pkt_removed,
   input  logic      tx_timeout,
   input  byte_cnt_t tx_pkt_byte_cnt
);

   queue_events_t rx_events;
   queue_events_t tx_events;
   reg_access_t   access;
   reg_data_t     rd_word;
   reg_idx_t      sweep_idx;
   logic          commit;
   delta_t        rx_delta;
   delta_t        tx_delta;

   // rx bytes count when the cpu reads a packet, tx bytes when it writes one
   assign rx_events = '{stored:   rx_pkt_stored,
                        removed:  rx_pkt_removed,
                        fault:    rx_pkt_dropped,
                        cpu_xfer: rx_pkt_removed,
                        byte_cnt: rx_pkt_byte_cnt};
   assign tx_events = '{stored:   tx_pkt_stored,
                        removed:  tx_pkt_removed,
                        fault:    tx_timeout,
                        cpu_xfer: tx_pkt_stored,
                        byte_cnt: tx_pkt_byte_cnt};

   reg_access u_reg_access (
      .clk         (clk),
      .reset       (reset),
      .req         (reg_req),
      .rd_wr_l     (reg_rd_wr_l),
      .addr        (reg_addr),
      .wr_data     (reg_wr_data),
      .rd_data     (reg_rd_data),
      .ack         (reg_ack),
      .access      (access),
      .rd_word     (rd_word),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

   stat_reg_file u_stat_reg_file (
      .clk       (clk),
      .reset     (reset),
      .access    (access),
      .rd_word   (rd_word),
      .sweep_idx (sweep_idx),
      .commit    (commit),
      .rx_delta  (rx_delta),
      .tx_delta  (tx_delta)
   );

   queue_stats #(.BASE(`CPU_QUEUE_RX_BASE)) u_rx_stats (
      .clk       (clk),
      .reset     (reset),
      .events    (rx_events),
      .sweep_idx (sweep_idx),
      .commit    (commit),
      .delta     (rx_delta)
   );

   queue_stats #(.BASE(`CPU_QUEUE_TX_BASE)) u_tx_stats (
      .clk       (clk),
      .reset     (reset),
      .events    (tx_events),
      .sweep_idx (sweep_idx),
      .commit    (commit),
      .delta     (tx_delta)
   );

endmodule

/* source/cpu_queue_stat_pkg.sv */
// --------------------
// types of the statistics side, events in and deltas out
// fault is the rx drop or the tx timeout strobe
// --------------------
`include "cpu_queue_consts.svh"

package cpu_queue_stat_pkg;

   // packet length in bytes
   typedef logic [`CPU_QUEUE_BYTE_CNT_W-1:0] byte_cnt_t;

   // change to one register since its last sweep write
   typedef logic signed [`CPU_QUEUE_DELTA_W-1:0] delta_t;

   // --------------------
   // strobes of one queue for one cycle

   typedef struct packed {
      logic      stored;
      logic      removed;
      logic      fault;
      // marks the packet whose bytes are counted
      logic      cpu_xfer;
      byte_cnt_t byte_cnt;
   } queue_events_t;

endpackage

/* source/delta_accum.sv */
// --------------------
// signed change of one counter since its last commit
// wraps in WIDTH bits, so events must be spaced by the caller
// --------------------
`timescale 1ns/1ps

module delta_accum
   import cpu_queue_stat_pkg::*;
#(
   parameter int WIDTH = 2
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    capture,
   input  delta_t                  amount,
   output logic signed [WIDTH-1:0] delta
);

   logic signed [WIDTH-1:0] step;

   // only the low bits matter, upper bits are sign or zero fill
   assign step = amount[WIDTH-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         delta <= '0;
      end else if (capture) begin
         // register takes the old delta this cycle, keep the new event
         delta <= step;
      end else begin
         delta <= delta + step;
      end
   end

endmodule

/* source/queue_stats.sv */
// --------------------
// five counter deltas of one queue, based at register BASE
// delta is zero while the sweep is outside this block
// counts are exact only with each event kind once per sweep
// --------------------
`timescale 1ns/1ps
`include "cpu_queue_consts.svh"

module queue_stats
   import cpu_queue_reg_pkg::*, cpu_queue_stat_pkg::*;
#(
   parameter int BASE = `CPU_QUEUE_RX_BASE
) (
   input  logic          clk,
   input  logic          reset,
   input  queue_events_t events,
   input  reg_idx_t      sweep_idx,
   input  logic          commit,
   output delta_t        delta
);

   localparam int CNT_W = 2;
   localparam int INQ_W = 3;
   localparam int PAD_W = `CPU_QUEUE_DELTA_W - `CPU_QUEUE_BYTE_CNT_W;

   reg_idx_t ofs;

   delta_t enq_amt;
   delta_t deq_amt;
   delta_t fault_amt;
   delta_t byte_amt;
   delta_t inq_amt;

   logic signed [CNT_W-1:0]              enq_d;
   logic signed [CNT_W-1:0]              deq_d;
   logic signed [CNT_W-1:0]              fault_d;
   logic signed [`CPU_QUEUE_DELTA_W-1:0] byte_d;
   logic signed [INQ_W-1:0]              inq_d;

   // indices below BASE wrap to large offsets and fall to the default
   assign ofs = sweep_idx - reg_idx_t'(BASE);

   // --------------------
   // per cycle amounts

   assign enq_amt   = {{(`CPU_QUEUE_DELTA_W-1){1'b0}}, events.stored};
   assign deq_amt   = {{(`CPU_QUEUE_DELTA_W-1){1'b0}}, events.removed};
   assign fault_amt = {{(`CPU_QUEUE_DELTA_W-1){1'b0}}, events.fault};
   assign byte_amt  = events.cpu_xfer ? {{PAD_W{1'b0}}, events.byte_cnt} : '0;

   always_comb begin
      case ({events.removed, events.stored})
         2'b01:   inq_amt = delta_t'(1);
         // all ones, minus one
         2'b10:   inq_amt = '1;
         default: inq_amt = '0;
      endcase
   end

   // --------------------
   // accumulators

   delta_accum #(.WIDTH(CNT_W)) u_enq (
      .clk     (clk),
      .reset   (reset),
      .capture (commit && ofs == `CPU_QUEUE_OFS_ENQ),
      .amount  (enq_amt),
      .delta   (enq_d)
   );

   delta_accum #(.WIDTH(CNT_W)) u_deq (
      .clk     (clk),
      .reset   (reset),
      .capture (commit && ofs == `CPU_QUEUE_OFS_DEQ),
      .amount  (deq_amt),
      .delta   (deq_d)
   );

   delta_accum #(.WIDTH(CNT_W)) u_fault (
      .clk     (clk),
      .reset   (reset),
      .capture (commit && ofs == `CPU_QUEUE_OFS_FAULT),
      .amount  (fault_amt),
      .delta   (fault_d)
   );

   delta_accum #(.WIDTH(`CPU_QUEUE_DELTA_W)) u_bytes (
      .clk     (clk),
      .reset   (reset),
      .capture (commit && ofs == `CPU_QUEUE_OFS_BYTES),
      .amount  (byte_amt),
      .delta   (byte_d)
   );

   delta_accum #(.WIDTH(INQ_W)) u_inq (
      .clk     (clk),
      .reset   (reset),
      .capture (commit && ofs == `CPU_QUEUE_OFS_INQ),
      .amount  (inq_amt),
      .delta   (inq_d)
   );

   // sign extended delta of the register under the sweep
   always_comb begin
      case (ofs)
         `CPU_QUEUE_OFS_ENQ:   delta = delta_t'(enq_d);
         `CPU_QUEUE_OFS_DEQ:   delta = delta_t'(deq_d);
         `CPU_QUEUE_OFS_FAULT: delta = delta_t'(fault_d);
         `CPU_QUEUE_OFS_BYTES: delta = byte_d;
         `CPU_QUEUE_OFS_INQ:   delta = delta_t'(inq_d);
         default:              delta = '0;
      endcase
   end

endmodule

/* source/reg_access.sv */
// --------------------
// register port, an access starts on the rising edge of req
// ack pulses one cycle later; req must fall before the next access
// bad addresses read as dead_beef and writes to them are dropped
// --------------------
`timescale 1ns/1ps
`include "cpu_queue_consts.svh"

module reg_access
   import cpu_queue_reg_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        req,
   input  logic        rd_wr_l,
   input  reg_addr_t   addr,
   input  reg_data_t   wr_data,
   output reg_data_t   rd_data,
   output logic        ack,
   output reg_access_t access,
   input  reg_data_t   rd_word,
   output logic        rx_queue_en,
   output logic        tx_queue_en
);

   logic     req_d1;
   logic     new_req;
   reg_idx_t idx;
   logic     addr_good;

   // disable bits of the control word
   logic     rx_dis;
   logic     tx_dis;

   // --------------------
   // request decode

   assign new_req   = req && !req_d1;
   assign idx       = addr[`CPU_QUEUE_IDX_W-1:0];
   assign addr_good = (addr[`CPU_QUEUE_ADDR_W-1:`CPU_QUEUE_IDX_W] == '0) &&
                      (idx < `CPU_QUEUE_NUM_REGS);

   assign access.valid   = new_req;
   assign access.write   = new_req && addr_good && !rd_wr_l;
   assign access.idx     = idx;
   assign access.wr_data = wr_data;

   // --------------------
   // ack, read data and control copy

   always_ff @(posedge clk) begin
      if (reset) begin
         req_d1  <= 1'b0;
         ack     <= 1'b0;
         rd_data <= '0;
         rx_dis  <= 1'b0;
         tx_dis  <= 1'b0;
      end else begin
         req_d1 <= req;
         ack    <= new_req;
         if (new_req) begin
            rd_data <= addr_good ? rd_word : `CPU_QUEUE_BAD_ADDR_DATA;
         end
         if (access.write && idx == `CPU_QUEUE_CONTROL) begin
            rx_dis <= wr_data[`CPU_QUEUE_CTRL_RX_DIS_POS];
            tx_dis <= wr_data[`CPU_QUEUE_CTRL_TX_DIS_POS];
         end
      end
   end

   assign rx_queue_en = !rx_dis;
   assign tx_queue_en = !tx_dis;

endmodule

/* source/stat_reg_file.sv */
// --------------------
// register RAM with a sweep that folds deltas in, one word per cycle
// first NUM_REGS cycles after reset clear the RAM, reads are undefined
// an access takes the port and holds the sweep for that cycle
// --------------------
`timescale 1ns/1ps
`include "cpu_queue_consts.svh"

module stat_reg_file
   import cpu_queue_reg_pkg::*, cpu_queue_stat_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  reg_access_t access,
   output reg_data_t   rd_word,
   output reg_idx_t    sweep_idx,
   output logic        commit,
   input  delta_t      rx_delta,
   input  delta_t      tx_delta
);

   localparam int       EXT_W    = `CPU_QUEUE_DATA_W - `CPU_QUEUE_DELTA_W;
   localparam reg_idx_t LAST_IDX = reg_idx_t'(`CPU_QUEUE_NUM_REGS - 1);

   reg_data_t ram [`CPU_QUEUE_NUM_REGS];

   sweep_state_t state;

   reg_idx_t  ram_idx;
   reg_data_t ram_word;
   reg_data_t ram_in;
   logic      ram_wr;
   logic      advance;
   delta_t    delta_sum;
   reg_data_t delta_ext;

   // --------------------
   // single port RAM

   always_ff @(posedge clk) begin
      if (ram_wr) begin
         ram[ram_idx] <= ram_in;
      end
   end

   assign ram_word = ram[ram_idx];
   assign rd_word  = ram_word;

   // blocks are disjoint, at most one delta is nonzero
   assign delta_sum = rx_delta + tx_delta;
   assign delta_ext = {{EXT_W{delta_sum[`CPU_QUEUE_DELTA_W-1]}}, delta_sum};

   // --------------------
   // port arbitration

   always_comb begin
      ram_idx = sweep_idx;
      ram_in  = '0;
      ram_wr  = 1'b0;
      commit  = 1'b0;
      advance = 1'b0;
      case (state)
         SWEEP_CLEAR: begin
            ram_wr  = 1'b1;
            advance = 1'b1;
         end
         SWEEP_RUN: begin
            if (access.valid) begin
               ram_idx = access.idx;
               ram_in  = access.wr_data;
               ram_wr  = access.write;
            end else begin
               // read, add, write back in the same cycle
               ram_in  = ram_word + delta_ext;
               ram_wr  = 1'b1;
               commit  = 1'b1;
               advance = 1'b1;
            end
         end
         default: begin
            ram_wr = 1'b0;
         end
      endcase
   end

   // --------------------
   // sweep index and state

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= SWEEP_CLEAR;
         sweep_idx <= '0;
      end else if (advance) begin
         if (sweep_idx == LAST_IDX) begin
            sweep_idx <= '0;
            state     <= SWEEP_RUN;
         end else begin
            sweep_idx <= sweep_idx + 1'b1;
         end
      end
   end

endmodule
